// ==== src.f ====
verilog/reduce_pkg.sv
verilog/core_if.sv
verilog/agu.sv
verilog/batch_dispatch.sv
verilog/reduce_core.sv
verilog/stream_ctrl.sv
verilog/result_drain.sv
verilog/reduce_top.sv
bench/reduce_tb.sv

// ==== bench/reduce_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module reduce_tb;

    localparam int N_CORES    = 4;
    localparam int DATA_W     = 32;
    // cycles any single wait may take
    localparam int WAIT_LIMIT = 400;

    logic              clk = 1'b0;
    logic              rst;
    logic              src_valid;
    logic [DATA_W-1:0] src_data;
    reduce_pkg::op_e   src_op;
    logic              src_last;
    logic              src_busy;
    logic              dst_ready;
    logic              dst_valid;
    logic [DATA_W-1:0] dst_data;
    logic              dst_last;

    integer            seed;
    int                checks;
    int                errors;

    // model state for the running batch
    logic [DATA_W-1:0] words [$];
    reduce_pkg::op_e   batch_op;
    logic [DATA_W-1:0] exp_res [N_CORES];

    always #2 clk = ~clk;

    reduce_top #(
        .N_CORES (N_CORES),
        .DATA_W  (DATA_W)
    ) reduce_top_i (
        .clk       (clk),
        .rst       (rst),
        .src_valid (src_valid),
        .src_data  (src_data),
        .src_op    (src_op),
        .src_last  (src_last),
        .src_busy  (src_busy),
        .dst_ready (dst_ready),
        .dst_valid (dst_valid),
        .dst_data  (dst_data),
        .dst_last  (dst_last)
    );

    // ======================================================================
    // compare tasks
    // ======================================================================

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic check_op(input string name, input reduce_pkg::op_e exp,
                            input reduce_pkg::op_e got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s expected %s got %s", $time, name, exp.name(), got.name());
        end
    endtask

    // ======================================================================
    // model
    // ======================================================================

    // uniform pick in lo..hi
    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + ((r & 32'h7fffffff) % (hi - lo + 1));
    endfunction

    // start value of a lane that saw no word
    function automatic logic [DATA_W-1:0] identity(input reduce_pkg::op_e op);
        if (op == reduce_pkg::op_min) begin
            return {DATA_W{1'b1}};
        end
        return {DATA_W{1'b0}};
    endfunction

    function automatic logic [DATA_W-1:0] combine(input reduce_pkg::op_e op,
                                                  input logic [DATA_W-1:0] acc,
                                                  input logic [DATA_W-1:0] w);
        if (op == reduce_pkg::op_sum) begin
            return acc + w;
        end else if (op == reduce_pkg::op_max) begin
            return (acc > w) ? acc : w;
        end else if (op == reduce_pkg::op_min) begin
            return (acc < w) ? acc : w;
        end
        return acc ^ w;
    endfunction

    // word k belongs to core k mod N_CORES
    function automatic void build_expected();
        for (int c = 0; c < N_CORES; c++) begin
            exp_res[c] = identity(batch_op);
        end
        foreach (words[k]) begin
            exp_res[k % N_CORES] = combine(batch_op, exp_res[k % N_CORES], words[k]);
        end
    endfunction

    // ======================================================================
    // stimulus and collection
    // ======================================================================

    task automatic apply_reset(input int cycles);
        @(negedge clk);
        rst       = 1'b1;
        src_valid = 1'b0;
        src_last  = 1'b0;
        repeat (cycles) @(negedge clk);
        check_flag("dst_valid", 1'b0, dst_valid);
        check_flag("dst_last", 1'b0, dst_last);
        check_flag("src_busy", 1'b0, src_busy);
        rst = 1'b0;
    endtask

    // last word stays on the bus until the caller clears it
    task automatic send_batch(input reduce_pkg::op_e op, input int len, input int max_gap);
        int gap;
        words.delete();
        batch_op = op;
        for (int k = 0; k < len; k++) begin
            gap = (k == 0) ? 0 : rand_range(0, max_gap);
            repeat (gap) begin
                @(negedge clk);
                src_valid = 1'b0;
                src_last  = 1'b0;
                src_data  = $random(seed);
            end
            @(negedge clk);
            src_valid = 1'b1;
            src_data  = $random(seed);
            // opcode only counts on the first word
            src_op    = (k == 0) ? op : reduce_pkg::op_e'(rand_range(0, 3));
            src_last  = (k == len - 1);
            words.push_back(src_data);
        end
    endtask

    task automatic collect_results(input bit rand_ready, input bit junk);
        int beats;
        int wait_cnt;
        bit finished;
        bit first;
        beats    = 0;
        wait_cnt = 0;
        finished = 1'b0;
        first    = 1'b1;
        while (!finished && wait_cnt < WAIT_LIMIT) begin
            @(negedge clk);
            src_valid = 1'b0;
            src_last  = 1'b0;
            dst_ready = rand_ready ? (rand_range(0, 3) != 0) : 1'b1;
            // words the DUT must ignore while busy
            if (junk && src_busy) begin
                src_valid = (rand_range(0, 1) != 0);
                src_data  = $random(seed);
                src_op    = reduce_pkg::op_e'(rand_range(0, 3));
                src_last  = (rand_range(0, 1) != 0);
            end
            #1;
            // busy holds until the final beat is taken
            check_flag("src_busy", 1'b1, src_busy);
            if (first) begin
                check_op("batch_op", batch_op, reduce_top_i.lanes.batch_op);
                first = 1'b0;
            end
            if (dst_valid && dst_ready) begin
                if (beats >= N_CORES) begin
                    errors++;
                    $display("error at %0t ns: more than %0d result beats", $time, N_CORES);
                    finished = 1'b1;
                end else begin
                    check_word("dst_data", exp_res[beats], dst_data);
                    check_flag("dst_last", beats == N_CORES - 1, dst_last);
                    beats++;
                    finished = dst_last;
                end
            end
            wait_cnt++;
        end
        if (finished) begin
            @(negedge clk);
            src_valid = 1'b0;
            src_last  = 1'b0;
            #1;
            check_flag("src_busy", 1'b0, src_busy);
            check_flag("dst_valid", 1'b0, dst_valid);
        end else begin
            errors++;
            $display("timeout: result stream did not finish within %0d cycles", WAIT_LIMIT);
            // recover for the next batch
            apply_reset(2);
        end
    endtask

    task automatic run_batch(input reduce_pkg::op_e op, input int len, input bit rand_ready,
                             input bit junk, input int max_gap);
        send_batch(op, len, max_gap);
        build_expected();
        collect_results(rand_ready, junk);
    endtask

    // reset lands after the first beat is out
    task automatic reset_mid_stream(input reduce_pkg::op_e op, input int len);
        int wait_cnt;
        send_batch(op, len, 0);
        wait_cnt = 0;
        @(negedge clk);
        src_valid = 1'b0;
        src_last  = 1'b0;
        dst_ready = 1'b1;
        #1;
        while (!dst_valid && wait_cnt < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            wait_cnt++;
        end
        if (!dst_valid) begin
            errors++;
            $display("timeout: no result beat appeared before the planned reset");
        end
        apply_reset(3);
    endtask

    task automatic report_test(input int num, input string name, input int batches,
                               input int err_mark);
        $display("test %0d %s: %0d batches, %0d errors", num, name, batches, errors - err_mark);
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================

    initial begin
        int err_mark;
        seed      = 32'h3075293f;
        checks    = 0;
        errors    = 0;
        rst       = 1'b1;
        src_valid = 1'b0;
        src_data  = '0;
        src_op    = reduce_pkg::op_sum;
        src_last  = 1'b0;
        dst_ready = 1'b1;
        apply_reset(8);

        // every opcode with the sink always ready
        err_mark = errors;
        for (int i = 0; i < 40; i++) begin
            run_batch(reduce_pkg::op_e'(i % 4), rand_range(1, 20), 1'b0, 1'b0, 0);
        end
        report_test(1, "random batches, ready high", 40, err_mark);

        // fewer words than cores
        err_mark = errors;
        for (int i = 0; i < 4; i++) begin
            for (int len = 1; len < N_CORES; len++) begin
                run_batch(reduce_pkg::op_e'(i), len, 1'b0, 1'b0, 0);
            end
        end
        report_test(2, "short batches, identity lanes", 4 * (N_CORES - 1), err_mark);

        // sink stalls at random
        err_mark = errors;
        for (int i = 0; i < 30; i++) begin
            run_batch(reduce_pkg::op_e'(rand_range(0, 3)), rand_range(1, 20), 1'b1, 1'b0, 2);
        end
        report_test(3, "random dst_ready", 30, err_mark);

        // source keeps pushing while busy
        err_mark = errors;
        for (int i = 0; i < 20; i++) begin
            run_batch(reduce_pkg::op_e'(rand_range(0, 3)), rand_range(1, 20), 1'b1, 1'b1, 2);
        end
        report_test(4, "words while busy", 20, err_mark);

        // reset mid-stream and then a clean batch
        err_mark = errors;
        for (int i = 0; i < 3; i++) begin
            reset_mid_stream(reduce_pkg::op_e'(rand_range(0, 3)), rand_range(4, 20));
            run_batch(reduce_pkg::op_e'(rand_range(0, 3)), rand_range(1, 20), 1'b1, 1'b0, 1);
        end
        report_test(5, "reset mid-stream", 6, err_mark);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/reduce_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module reduce_top #(
    parameter int N_CORES = reduce_pkg::DEF_N_CORES,
    parameter int DATA_W  = reduce_pkg::DEF_DATA_W
) (
    input  wire                   clk,
    input  wire                   rst,
    // source side, one strobe per word
    input  wire                   src_valid,
    input  wire [DATA_W-1:0]      src_data,
    input  wire reduce_pkg::op_e  src_op,
    input  wire                   src_last,
    output wire                   src_busy,
    // result stream
    input  wire                   dst_ready,
    output wire                   dst_valid,
    output wire [DATA_W-1:0]      dst_data,
    output wire                   dst_last
);

    // index width for the beat counter
    localparam int IDX_W = $clog2(N_CORES);

    wire batch_drained;

    core_if #(
        .N_CORES (N_CORES),
        .DATA_W  (DATA_W)
    ) lanes ();

    // ======================================================================
    // dispatcher
    // ======================================================================

    batch_dispatch #(
        .N_CORES (N_CORES),
        .DATA_W  (DATA_W)
    ) batch_dispatch_i (
        .clk           (clk),
        .rst           (rst),
        .src_valid     (src_valid),
        .src_data      (src_data),
        .src_op        (src_op),
        .src_last      (src_last),
        .batch_drained (batch_drained),
        .src_busy      (src_busy),
        .lanes         (lanes.feed)
    );

    // ======================================================================
    // reduction cores
    // ======================================================================

    for (genvar c = 0; c < N_CORES; c++) begin : g_core
        reduce_core #(
            .CORE_ID (c),
            .N_CORES (N_CORES),
            .DATA_W  (DATA_W)
        ) reduce_core_i (
            .clk   (clk),
            .rst   (rst),
            .lanes (lanes.core)
        );
    end

    // ======================================================================
    // drain
    // ======================================================================

    result_drain #(
        .N_CORES (N_CORES),
        .DATA_W  (DATA_W),
        .IDX_W   (IDX_W)
    ) result_drain_i (
        .clk           (clk),
        .rst           (rst),
        .lanes         (lanes.drain),
        .dst_ready     (dst_ready),
        .dst_valid     (dst_valid),
        .dst_last      (dst_last),
        .dst_data      (dst_data),
        .batch_drained (batch_drained)
    );

endmodule

`default_nettype wire

// ==== verilog/result_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_drain #(
    parameter int N_CORES = 4,
    parameter int DATA_W  = 32,
    parameter int IDX_W   = 2
) (
    input  wire               clk,
    input  wire               rst,
    core_if.drain             lanes,
    input  wire               dst_ready,
    output logic              dst_valid,
    output logic              dst_last,
    output logic [DATA_W-1:0] dst_data,
    output logic              batch_drained
);

    logic             stream_v;
    logic [IDX_W-1:0] beat_index;

    // ======================================================================
    // pacing
    // ======================================================================

    // done pulses of all cores arrive together
    stream_ctrl #(
        .N_CORES (N_CORES),
        .IDX_W   (IDX_W)
    ) stream_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .last       (lanes.done),
        .dst_ready  (dst_ready),
        .dst_valid  (dst_valid),
        .dst_last   (dst_last),
        .stream_v   (stream_v),
        .beat_index (beat_index)
    );

    // ======================================================================
    // data path
    // ======================================================================

    // same edge as dst_valid, so data and valid line up
    // results stay stable until the next batch starts
    always_ff @(posedge clk) begin
        if (stream_v) begin
            dst_data <= lanes.result[beat_index];
        end
    end

    // final beat taken by the sink
    assign batch_drained = dst_valid & dst_last & dst_ready;

endmodule

`default_nettype wire

// ==== verilog/stream_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_ctrl #(
    parameter int N_CORES = 4,
    parameter int IDX_W   = 2
) (
    input  wire                clk,
    input  wire                rst,
    input  wire [N_CORES-1:0]  last,
    input  wire                dst_ready,
    output logic               dst_valid,
    output logic               dst_last,
    output logic               stream_v,
    output logic [IDX_W-1:0]   beat_index
);

    logic last_n;
    logic last_nn;
    logic last_keep;
    logic stream_ok;
    logic stream_ok_keep;
    logic stream_active;
    logic start;
    logic last_stream;

    // ======================================================================
    // done delay and pending flag
    // ======================================================================

    // two stages of "any core done"
    always_ff @(posedge clk) begin
        if (rst) begin
            last_n  <= 1'b0;
            last_nn <= 1'b0;
        end else begin
            last_n  <= (last != '0);
            last_nn <= last_n;
        end
    end

    // remember the done until the sink is ready
    always_ff @(posedge clk) begin
        if (rst) begin
            last_keep <= 1'b0;
        end else if (stream_ok) begin
            last_keep <= 1'b0;
        end else if (last_nn) begin
            last_keep <= 1'b1;
        end
    end

    assign stream_ok = (last_nn | last_keep) & dst_ready;

    // registered copy, kicks the index counter
    always_ff @(posedge clk) begin
        if (rst) begin
            stream_ok_keep <= 1'b0;
        end else if (dst_ready) begin
            stream_ok_keep <= stream_ok;
        end
    end

    assign start = dst_ready & stream_ok_keep;

    // ======================================================================
    // beat sequencing
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            stream_active <= 1'b0;
        end else if (dst_ready & last_stream) begin
            stream_active <= 1'b0;
        end else if (dst_ready & stream_ok) begin
            stream_active <= 1'b1;
        end
    end

    // core index 0 .. N_CORES-1, advances only with dst_ready
    agu #(
        .W   (IDX_W),
        .INI (0),
        .FIN (N_CORES - 1)
    ) agu_stream_i (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .en    (dst_ready),
        .data  (beat_index),
        .last  (last_stream)
    );

    // beat at beat_index goes into the output register
    assign stream_v = stream_active & dst_ready;

    // ======================================================================
    // output register
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            dst_valid <= 1'b0;
            dst_last  <= 1'b0;
        end else if (dst_ready) begin
            dst_valid <= stream_active;
            dst_last  <= stream_active & last_stream;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/reduce_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module reduce_core #(
    parameter int CORE_ID = 0,
    parameter int N_CORES = 4,
    parameter int DATA_W  = 32
) (
    input  wire  clk,
    input  wire  rst,
    core_if.core lanes
);

    reduce_pkg::core_state_e state;
    logic [DATA_W-1:0]       acc;
    logic [DATA_W-1:0]       base;
    logic                    my_valid;
    logic                    any_valid;
    logic                    batch_start;

    // fold one word into the running value
    function automatic logic [DATA_W-1:0] fold(
        input reduce_pkg::op_e    op,
        input logic [DATA_W-1:0]  a,
        input logic [DATA_W-1:0]  b
    );
        logic [DATA_W-1:0] r;
        case (op)
            reduce_pkg::op_sum: r = a + b;
            reduce_pkg::op_max: r = (b > a) ? b : a;
            reduce_pkg::op_min: r = (b < a) ? b : a;
            default:            r = a ^ b;
        endcase
        return r;
    endfunction

    assign my_valid    = lanes.lane_valid[CORE_ID];
    assign any_valid   = (lanes.lane_valid != N_CORES'(0));
    // any word outside accum opens a new batch, even on other lanes
    assign batch_start = any_valid & (state != reduce_pkg::core_accum);
    // identity: all ones for min, zero otherwise
    assign base = !batch_start ? acc :
                  (lanes.batch_op == reduce_pkg::op_min) ? '1 : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= reduce_pkg::core_idle;
        end else if (lanes.batch_end) begin
            state <= reduce_pkg::core_done;
        end else if (any_valid) begin
            state <= reduce_pkg::core_accum;
        end else if (state == reduce_pkg::core_done) begin
            state <= reduce_pkg::core_idle;
        end
    end

    // accumulator, held through done and idle
    always_ff @(posedge clk) begin
        if (batch_start || my_valid) begin
            acc <= my_valid ? fold(lanes.batch_op, base, lanes.lane_data) : base;
        end
    end

    assign lanes.done[CORE_ID]   = (state == reduce_pkg::core_done);
    assign lanes.result[CORE_ID] = acc;

endmodule

`default_nettype wire

// ==== verilog/batch_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module batch_dispatch #(
    parameter int N_CORES = 4,
    parameter int DATA_W  = 32
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   src_valid,
    input  wire [DATA_W-1:0]      src_data,
    input  wire reduce_pkg::op_e  src_op,
    input  wire                   src_last,
    input  wire                   batch_drained,
    output logic                  src_busy,
    core_if.feed                  lanes
);

    reduce_pkg::dispatch_state_e state;
    logic [N_CORES-1:0]          ptr;
    logic [N_CORES-1:0]          lane_sel;
    logic                        take;

    // first word of a batch always lands on core 0
    assign lane_sel = (state == reduce_pkg::disp_idle) ? N_CORES'(1) : ptr;
    // words are dropped while the results drain
    assign take     = src_valid & (state != reduce_pkg::disp_drain);
    assign src_busy = (state == reduce_pkg::disp_drain);

    // ======================================================================
    // control
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= reduce_pkg::disp_idle;
            ptr              <= N_CORES'(1);
            lanes.lane_valid <= '0;
            lanes.batch_end  <= 1'b0;
        end else begin
            // strobes, cleared unless a word goes out
            lanes.lane_valid <= '0;
            lanes.batch_end  <= 1'b0;
            if (take) begin
                lanes.lane_valid <= lane_sel;
                // rotate left for the next word
                ptr              <= {lane_sel[N_CORES-2:0], lane_sel[N_CORES-1]};
                lanes.batch_end  <= src_last;
                state            <= src_last ? reduce_pkg::disp_drain
                                             : reduce_pkg::disp_batch;
            end else if (state == reduce_pkg::disp_drain && batch_drained) begin
                state <= reduce_pkg::disp_idle;
            end
        end
    end

    // ======================================================================
    // payload
    // ======================================================================

    always_ff @(posedge clk) begin
        if (take) begin
            lanes.lane_data <= src_data;
        end
        // opcode only sampled with the first word
        if (take && state == reduce_pkg::disp_idle) begin
            lanes.batch_op <= src_op;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/agu.sv ====
`timescale 1ns/1ps
`default_nettype none

module agu #(
    parameter int W   = 2,
    parameter int INI = 0,
    parameter int FIN = 3
) (
    input  wire          clk,
    input  wire          rst,
    input  wire          start,
    input  wire          en,
    output logic [W-1:0] data,
    output logic         last
);

    logic [W-1:0] cnt;
    logic         run;
    logic [W-1:0] cur;
    logic         active;

    // start restarts at INI in the same cycle
    assign cur    = start ? W'(INI) : cnt;
    assign active = start | run;
    assign data   = cur;
    assign last   = active & (cur == W'(FIN));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= W'(INI);
            run <= 1'b0;
        end else if (en & active) begin
            if (last) begin
                // wrap and park at INI until next start
                cnt <= W'(INI);
                run <= 1'b0;
            end else begin
                cnt <= cur + 1'b1;
                run <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/core_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface core_if #(
    parameter int N_CORES = 4,
    parameter int DATA_W  = 32
);

    // ======================================================================
    // dispatcher to cores
    // ======================================================================

    // one-hot, which core takes lane_data this cycle
    logic [N_CORES-1:0]  lane_valid;
    // shared word bus
    logic [DATA_W-1:0]   lane_data;
    // opcode of the running batch
    reduce_pkg::op_e     batch_op;
    // single cycle, after the final word
    logic                batch_end;

    // ======================================================================
    // cores to drain
    // ======================================================================

    // nets, since every core drives only its own slice
    wire  [N_CORES-1:0]  done;
    wire  [DATA_W-1:0]   result [N_CORES];

    modport feed (
        output lane_valid, lane_data, batch_op, batch_end
    );

    modport core (
        input  lane_valid, lane_data, batch_op, batch_end,
        output done, result
    );

    modport drain (
        input  done, result
    );

endinterface

`default_nettype wire

// ==== verilog/reduce_pkg.sv ====
`default_nettype none

package reduce_pkg;

    // ======================================================================
    // default sizes, overridden from the top level
    // ======================================================================

    // core count, power of two
    localparam int DEF_N_CORES = 4;
    // word width of source and result
    localparam int DEF_DATA_W  = 32;

    // ======================================================================
    // encodings
    // ======================================================================

    // reduction opcode, one per batch
    typedef enum logic [1:0] {
        op_sum = 2'd0,
        op_max = 2'd1,
        op_min = 2'd2,
        op_xor = 2'd3
    } op_e;

    // per-core lane state
    typedef enum logic [1:0] {
        core_idle  = 2'd0,
        core_accum = 2'd1,
        core_done  = 2'd2
    } core_state_e;

    // dispatcher batch state
    typedef enum logic [1:0] {
        disp_idle  = 2'd0,
        disp_batch = 2'd1,
        disp_drain = 2'd2
    } dispatch_state_e;

endpackage

`default_nettype wire
